// ==== source/ppu_pkg.sv ====
// Shared widths, special posit encodings and the opcode type, imported by every PPU module.
`default_nettype none

package ppu_pkg;

  // Posit word width, posit<8,0>.
  localparam int POSIT_N = 8;

  // Fraction with the hidden bit.
  // At most five stored fraction bits survive the sign and shortest regime.
  localparam int FRAC_W = 6;

  // Signed scale, regime value only since ES is zero.
  localparam int SCALE_W = 5;

  // Largest and smallest scale a posit<8,0> can encode.
  localparam int MAX_SCALE = 6;
  localparam int MIN_SCALE = -6;

  // Raw execute fraction.
  // Two integer bits on top, then fraction, guard and sticky positions.
  localparam int ACC_W = 16;

  // Bit index of the units position inside the raw fraction.
  localparam int ACC_POINT = ACC_W - 2;

  // One posit word.
  typedef logic [POSIT_N-1:0] posit_t;

  // Special encodings.
  localparam posit_t NAR_PATTERN    = 8'h80;
  localparam posit_t ZERO_PATTERN   = 8'h00;
  localparam posit_t MAXPOS_PATTERN = 8'h7F;
  localparam posit_t MINPOS_PATTERN = 8'h01;

  // Supported operations.
  // Code 2'b11 is unused.
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10
  } operation_e;

endpackage : ppu_pkg

`default_nettype wire

// ==== source/ppu_decode.sv ====
// Decode stage of the PPU; splits both operand posits into sign, scale and fraction and registers them.
`timescale 1ns/1ps
`default_nettype none

module ppu_decode
  import ppu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  operation_e                op_i,
  input  posit_t                    operand1_i,
  input  posit_t                    operand2_i,
  output logic                      valid_o,
  output operation_e                op_o,
  output logic                      a_sign_o,
  output logic signed [SCALE_W-1:0] a_scale_o,
  output logic [FRAC_W-1:0]         a_frac_o,
  output logic                      a_zero_o,
  output logic                      a_nar_o,
  output logic                      b_sign_o,
  output logic signed [SCALE_W-1:0] b_scale_o,
  output logic [FRAC_W-1:0]         b_frac_o,
  output logic                      b_zero_o,
  output logic                      b_nar_o
);

  // Returns {scale, fraction with hidden one} of a posit.
  function automatic logic [SCALE_W+FRAC_W-1:0] split_posit(input posit_t p);
    posit_t                    mag;
    logic [POSIT_N-2:0]        body;
    logic [POSIT_N-2:0]        rest;
    logic [3:0]                run;
    logic                      done;
    logic signed [SCALE_W-1:0] scale;
    logic [FRAC_W-1:0]         frac;
    mag  = p[POSIT_N-1] ? -p : p;
    body = mag[POSIT_N-2:0];
    run  = 4'd0;
    done = 1'b0;
    // Length of the regime run.
    for (int i = POSIT_N - 2; i >= 0; i--) begin
      if (!done && (body[i] == body[POSIT_N-2])) begin
        run = run + 4'd1;
      end else begin
        done = 1'b1;
      end
    end
    if (body[POSIT_N-2]) begin
      scale = SCALE_W'(run) - SCALE_W'(1);
    end else begin
      scale = -SCALE_W'(run);
    end
    // Drop the run and its terminator, the rest is the stored fraction.
    rest = body << (run + 4'd1);
    frac = {1'b1, rest[POSIT_N-2 -: FRAC_W-1]};
    return {scale, frac};
  endfunction

  logic [SCALE_W+FRAC_W-1:0] a_fields;
  logic [SCALE_W+FRAC_W-1:0] b_fields;

  assign a_fields = split_posit(operand1_i);
  assign b_fields = split_posit(operand2_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Fields only load with a valid operation.
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      op_o      <= op_i;
      a_sign_o  <= operand1_i[POSIT_N-1];
      a_scale_o <= a_fields[SCALE_W+FRAC_W-1:FRAC_W];
      a_frac_o  <= a_fields[FRAC_W-1:0];
      a_zero_o  <= (operand1_i == ZERO_PATTERN);
      a_nar_o   <= (operand1_i == NAR_PATTERN);
      b_sign_o  <= operand2_i[POSIT_N-1];
      b_scale_o <= b_fields[SCALE_W+FRAC_W-1:FRAC_W];
      b_frac_o  <= b_fields[FRAC_W-1:0];
      b_zero_o  <= (operand2_i == ZERO_PATTERN);
      b_nar_o   <= (operand2_i == NAR_PATTERN);
    end
  end

  // A registered operation always carries a known opcode.
  op_defined_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> (op_o inside {OP_ADD, OP_SUB, OP_MUL}));

endmodule : ppu_decode

`default_nettype wire

// ==== source/ppu_execute.sv ====
// Execute stage of the PPU; exact add, subtract or multiply on decoded operands, raw result registered.
`timescale 1ns/1ps
`default_nettype none

module ppu_execute
  import ppu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  operation_e                op_i,
  input  logic                      a_sign_i,
  input  logic signed [SCALE_W-1:0] a_scale_i,
  input  logic [FRAC_W-1:0]         a_frac_i,
  input  logic                      a_zero_i,
  input  logic                      a_nar_i,
  input  logic                      b_sign_i,
  input  logic signed [SCALE_W-1:0] b_scale_i,
  input  logic [FRAC_W-1:0]         b_frac_i,
  input  logic                      b_zero_i,
  input  logic                      b_nar_i,
  output logic                      valid_o,
  output logic                      res_sign_o,
  output logic signed [SCALE_W-1:0] res_scale_o,
  output logic [ACC_W-1:0]          res_frac_o,
  output logic                      res_zero_o,
  output logic                      res_nar_o
);

  logic                      eff_b_sign;
  logic                      eff_sub;
  logic                      a_larger;
  logic signed [SCALE_W-1:0] scale_diff;
  logic [3:0]                shift_amt;
  logic [ACC_W-1:0]          a_wide;
  logic [ACC_W-1:0]          b_wide;
  logic [ACC_W-1:0]          big_wide;
  logic [ACC_W-1:0]          small_wide;
  logic [2*ACC_W-1:0]        small_ext;
  logic [ACC_W-1:0]          small_aligned;
  logic [ACC_W-1:0]          magnitude;
  logic [2*FRAC_W-1:0]       product;

  logic                      sign_d;
  logic signed [SCALE_W-1:0] scale_d;
  logic [ACC_W-1:0]          frac_d;
  logic                      zero_d;
  logic                      nar_d;

  // Subtract is add with b negated.
  assign eff_b_sign = b_sign_i ^ (op_i == OP_SUB);
  assign eff_sub    = a_sign_i ^ eff_b_sign;

  // Hidden bit lands on the units position.
  assign a_wide = {1'b0, a_frac_i, {(ACC_W-FRAC_W-1){1'b0}}};
  assign b_wide = {1'b0, b_frac_i, {(ACC_W-FRAC_W-1){1'b0}}};

  assign a_larger = (a_scale_i > b_scale_i) ||
                    ((a_scale_i == b_scale_i) && (a_frac_i >= b_frac_i));

  assign big_wide   = a_larger ? a_wide : b_wide;
  assign small_wide = a_larger ? b_wide : a_wide;
  assign scale_diff = a_larger ? (a_scale_i - b_scale_i) : (b_scale_i - a_scale_i);
  assign shift_amt  = scale_diff[3:0];

  // Bits shifted past the LSB fold into a sticky bit.
  assign small_ext     = {small_wide, {ACC_W{1'b0}}} >> shift_amt;
  assign small_aligned = small_ext[2*ACC_W-1 -: ACC_W] |
                         ACC_W'(|small_ext[ACC_W-1:0]);

  assign magnitude = eff_sub ? (big_wide - small_aligned) : (big_wide + small_aligned);

  assign product = a_frac_i * b_frac_i;

  always_comb begin
    nar_d   = a_nar_i | b_nar_i;
    sign_d  = a_sign_i;
    scale_d = a_scale_i;
    frac_d  = a_wide;
    zero_d  = 1'b0;
    if (op_i == OP_MUL) begin
      sign_d  = a_sign_i ^ b_sign_i;
      scale_d = a_scale_i + b_scale_i;
      frac_d  = {product, {(ACC_W-2*FRAC_W){1'b0}}};
      zero_d  = a_zero_i | b_zero_i;
    end else if (a_zero_i) begin
      // Zero plus b passes b through.
      sign_d  = eff_b_sign;
      scale_d = b_scale_i;
      frac_d  = b_wide;
      zero_d  = b_zero_i;
    end else if (!b_zero_i) begin
      // Sign follows the larger magnitude.
      sign_d  = a_larger ? a_sign_i : eff_b_sign;
      scale_d = a_larger ? a_scale_i : b_scale_i;
      frac_d  = magnitude;
      zero_d  = (magnitude == '0);
    end
    // NaR wins over everything.
    if (nar_d) begin
      zero_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_sign_o  <= sign_d;
      res_scale_o <= scale_d;
      res_frac_o  <= frac_d;
      res_zero_o  <= zero_d;
      res_nar_o   <= nar_d;
    end
  end

  // Zero and NaR are exclusive on a valid raw result.
  zero_nar_excl_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> !(res_zero_o && res_nar_o));

endmodule : ppu_execute

`default_nettype wire

// ==== source/ppu_result.sv ====
// Result stage of the PPU; normalizes and rounds the raw result, then encodes and registers the posit.
`timescale 1ns/1ps
`default_nettype none

module ppu_result
  import ppu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  logic                      res_sign_i,
  input  logic signed [SCALE_W-1:0] res_scale_i,
  input  logic [ACC_W-1:0]          res_frac_i,
  input  logic                      res_zero_i,
  input  logic                      res_nar_i,
  output logic                      valid_o,
  output posit_t                    result_o
);

  logic [4:0]                      lead;
  logic [ACC_W-1:0]                norm;
  logic signed [SCALE_W+1:0]       scale_n;
  logic [2:0]                      shift_amt;
  logic signed [ACC_W+POSIT_N-1:0] regime_vec;
  logic signed [ACC_W+POSIT_N-1:0] shifted;
  logic [POSIT_N-2:0]              body;
  logic                            guard;
  logic                            sticky;
  logic [POSIT_N-2:0]              body_rnd;
  posit_t                          magnitude;
  posit_t                          result_d;
  logic                            nar_q;

  // Leading one of the raw fraction.
  always_comb begin
    lead = '0;
    for (int i = 0; i < ACC_W; i++) begin
      if (res_frac_i[i]) begin
        lead = 5'(i);
      end
    end
  end

  assign norm    = res_frac_i << (5'(ACC_W - 1) - lead);
  assign scale_n = {{2{res_scale_i[SCALE_W-1]}}, res_scale_i} + $signed({2'b00, lead})
                   - (SCALE_W+2)'(ACC_POINT);

  // Regime run length minus one, either sign.
  assign shift_amt = scale_n[SCALE_W+1] ? ~scale_n[2:0] : scale_n[2:0];

  // Prefix 10 grows a ones run, 01 a zeros run.
  assign regime_vec = {~scale_n[SCALE_W+1], scale_n[SCALE_W+1], norm[ACC_W-2:0],
                       {(POSIT_N-1){1'b0}}};
  assign shifted    = regime_vec >>> shift_amt;

  assign body   = shifted[ACC_W+POSIT_N-1 -: POSIT_N-1];
  assign guard  = shifted[ACC_W];
  assign sticky = |shifted[ACC_W-1:0];

  // Nearest, ties to even.
  assign body_rnd = body + (POSIT_N-1)'(guard & (sticky | body[0]));

  always_comb begin
    if (scale_n >= MAX_SCALE) begin
      magnitude = MAXPOS_PATTERN;
    end else if (scale_n < MIN_SCALE) begin
      magnitude = MINPOS_PATTERN;
    end else begin
      magnitude = {1'b0, body_rnd};
    end
    if (res_nar_i) begin
      result_d = NAR_PATTERN;
    end else if (res_zero_i) begin
      result_d = ZERO_PATTERN;
    end else if (res_sign_i) begin
      result_d = -magnitude;
    end else begin
      result_d = magnitude;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= ZERO_PATTERN;
      nar_q    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= result_d;
        nar_q    <= res_nar_i;
      end
    end
  end

  // Only a NaR operand may produce NaR.
  nar_only_from_nar_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !nar_q) |-> (result_o != NAR_PATTERN));

endmodule : ppu_result

`default_nettype wire

// ==== source/ppu.sv ====
// Top level of the posit<8,0> processing unit; three-stage pipeline from operands to posit result.
`timescale 1ns/1ps
`default_nettype none

module ppu
  import ppu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       in_valid_i,
  input  operation_e op_i,
  input  posit_t     operand1_i,
  input  posit_t     operand2_i,
  output posit_t     result_o,
  output logic       out_valid_o
);

  logic                      dec_valid;
  operation_e                dec_op;
  logic                      a_sign;
  logic signed [SCALE_W-1:0] a_scale;
  logic [FRAC_W-1:0]         a_frac;
  logic                      a_zero;
  logic                      a_nar;
  logic                      b_sign;
  logic signed [SCALE_W-1:0] b_scale;
  logic [FRAC_W-1:0]         b_frac;
  logic                      b_zero;
  logic                      b_nar;

  logic                      res_valid;
  logic                      res_sign;
  logic signed [SCALE_W-1:0] res_scale;
  logic [ACC_W-1:0]          res_frac;
  logic                      res_zero;
  logic                      res_nar;

  ppu_decode u_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (in_valid_i),
    .op_i       (op_i),
    .operand1_i (operand1_i),
    .operand2_i (operand2_i),
    .valid_o    (dec_valid),
    .op_o       (dec_op),
    .a_sign_o   (a_sign),
    .a_scale_o  (a_scale),
    .a_frac_o   (a_frac),
    .a_zero_o   (a_zero),
    .a_nar_o    (a_nar),
    .b_sign_o   (b_sign),
    .b_scale_o  (b_scale),
    .b_frac_o   (b_frac),
    .b_zero_o   (b_zero),
    .b_nar_o    (b_nar)
  );

  ppu_execute u_execute (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (dec_valid),
    .op_i        (dec_op),
    .a_sign_i    (a_sign),
    .a_scale_i   (a_scale),
    .a_frac_i    (a_frac),
    .a_zero_i    (a_zero),
    .a_nar_i     (a_nar),
    .b_sign_i    (b_sign),
    .b_scale_i   (b_scale),
    .b_frac_i    (b_frac),
    .b_zero_i    (b_zero),
    .b_nar_i     (b_nar),
    .valid_o     (res_valid),
    .res_sign_o  (res_sign),
    .res_scale_o (res_scale),
    .res_frac_o  (res_frac),
    .res_zero_o  (res_zero),
    .res_nar_o   (res_nar)
  );

  ppu_result u_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (res_valid),
    .res_sign_i  (res_sign),
    .res_scale_i (res_scale),
    .res_frac_i  (res_frac),
    .res_zero_i  (res_zero),
    .res_nar_i   (res_nar),
    .valid_o     (out_valid_o),
    .result_o    (result_o)
  );

endmodule : ppu

`default_nettype wire

// ==== verif/ppu_tb.sv ====
// Random-stimulus testbench for the PPU; checks results and latency against a real-valued posit model.
`timescale 1ns/1ps
`default_nettype none

module ppu_tb
  import ppu_pkg::*;
;

  logic       clk_i;
  logic       rst_n_i;
  logic       in_valid_i;
  operation_e op_i;
  posit_t     operand1_i;
  posit_t     operand2_i;
  posit_t     result_o;
  logic       out_valid_o;

  integer seed;
  int     edge_cnt;
  int     in_count;
  int     out_count;
  int     posit_errs;
  int     flag_errs;
  int     count_errs;
  int     other_errs;
  int     drain_cycles;

  // Operations in flight, oldest first.
  posit_t exp_q[$];
  int     edge_q[$];
  string  name_q[$];

  posit_t exp_p;
  int     exp_e;
  string  exp_name;

  ppu dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .op_i        (op_i),
    .operand1_i  (operand1_i),
    .operand2_i  (operand2_i),
    .result_o    (result_o),
    .out_valid_o (out_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    edge_cnt = edge_cnt + 1;
  end

  function automatic real pow2(input int k);
    real v;
    v = 1.0;
    for (int i = 0; i < k; i++) v = v * 2.0;
    for (int i = 0; i > k; i--) v = v / 2.0;
    return v;
  endfunction

  // Value of a posit<8,0> pattern other than NaR.
  function automatic real posit_to_real(input posit_t p);
    posit_t mag;
    int     k;
    int     pos;
    real    v;
    real    weight;
    if (p == ZERO_PATTERN) return 0.0;
    mag = p[POSIT_N-1] ? -p : p;
    pos = POSIT_N - 2;
    if (mag[pos]) begin
      k = -1;
      while (pos >= 0 && mag[pos]) begin
        k++;
        pos--;
      end
    end else begin
      k = 0;
      while (pos >= 0 && !mag[pos]) begin
        k--;
        pos--;
      end
    end
    // Skip the regime terminator.
    pos--;
    v = 1.0;
    weight = 0.5;
    while (pos >= 0) begin
      if (mag[pos]) v = v + weight;
      weight = weight / 2.0;
      pos--;
    end
    v = v * pow2(k);
    return p[POSIT_N-1] ? -v : v;
  endfunction

  // Nearest pattern, ties to the even pattern, never rounding to zero or NaR.
  function automatic posit_t real_to_posit(input real r);
    real    mag;
    real    lo;
    real    hi;
    posit_t pat;
    mag = (r < 0.0) ? -r : r;
    if (r == 0.0) return ZERO_PATTERN;
    if (mag >= posit_to_real(MAXPOS_PATTERN)) begin
      pat = MAXPOS_PATTERN;
    end else if (mag <= posit_to_real(MINPOS_PATTERN)) begin
      pat = MINPOS_PATTERN;
    end else begin
      pat = MINPOS_PATTERN;
      for (int i = 1; i < 127; i++) begin
        lo = posit_to_real(posit_t'(i));
        hi = posit_to_real(posit_t'(i + 1));
        if (mag >= lo && mag < hi) begin
          if (mag - lo < hi - mag) pat = posit_t'(i);
          else if (mag - lo > hi - mag) pat = posit_t'(i + 1);
          else pat = i[0] ? posit_t'(i + 1) : posit_t'(i);
        end
      end
    end
    return (r < 0.0) ? -pat : pat;
  endfunction

  function automatic posit_t model_result(input operation_e op, input posit_t a, input posit_t b);
    real va;
    real vb;
    real r;
    if (a == NAR_PATTERN || b == NAR_PATTERN) return NAR_PATTERN;
    va = posit_to_real(a);
    vb = posit_to_real(b);
    case (op)
      OP_ADD:  r = va + vb;
      OP_SUB:  r = va - vb;
      default: r = va * vb;
    endcase
    return real_to_posit(r);
  endfunction

  function automatic string op_text(input operation_e op);
    case (op)
      OP_ADD:  return "add";
      OP_SUB:  return "sub";
      OP_MUL:  return "mul";
      default: return "bad";
    endcase
  endfunction

  task automatic compare_posit(input string name, input posit_t expected, input posit_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected 8'h%02h actual 8'h%02h", name, expected, actual);
      posit_errs++;
    end
  endtask

  task automatic compare_logic(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %b actual %b", name, expected, actual);
      flag_errs++;
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
      count_errs++;
    end
  endtask

  // Inputs and outputs are both stable at the falling edge.
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (out_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Output appeared at edge %0d with no operation in flight", edge_cnt);
          other_errs++;
        end else begin
          exp_p    = exp_q.pop_front();
          exp_e    = edge_q.pop_front();
          exp_name = name_q.pop_front();
          compare_count({exp_name, " latency"}, 3, edge_cnt - exp_e);
          compare_posit(exp_name, exp_p, result_o);
          out_count++;
        end
      end else if (exp_q.size() != 0 && edge_q[0] + 3 == edge_cnt) begin
        $display("Result of %s missing three edges after it was sent", name_q[0]);
        other_errs++;
        void'(exp_q.pop_front());
        void'(edge_q.pop_front());
        void'(name_q.pop_front());
      end
      if (in_valid_i) begin
        exp_q.push_back(model_result(op_i, operand1_i, operand2_i));
        // Latency counts from the edge after which the operation was driven.
        edge_q.push_back(edge_cnt);
        name_q.push_back($sformatf("%s 8'h%02h 8'h%02h", op_text(op_i), operand1_i, operand2_i));
        in_count++;
      end
    end
  end

  function automatic posit_t pick_operand();
    int r;
    r = $random(seed);
    if (r[3:2] == 2'b00) begin
      case (r[1:0])
        2'd0:    return ZERO_PATTERN;
        2'd1:    return NAR_PATTERN;
        2'd2:    return MAXPOS_PATTERN;
        default: return MINPOS_PATTERN;
      endcase
    end
    return posit_t'($random(seed));
  endfunction

  function automatic operation_e pick_op();
    return operation_e'({$random(seed)} % 3);
  endfunction

  task automatic send_op(input operation_e op, input posit_t a, input posit_t b);
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b1;
    op_i       = op;
    operand1_i = a;
    operand2_i = b;
  endtask

  // Stale data on the inputs while valid is low.
  task automatic idle_cycle();
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
    op_i       = pick_op();
    operand1_i = posit_t'($random(seed));
    operand2_i = posit_t'($random(seed));
  endtask

  task automatic run_directed();
    // Cancellation and widely different scales.
    send_op(OP_SUB, 8'h48, 8'h48);
    send_op(OP_ADD, 8'h48, 8'hB8);
    send_op(OP_ADD, MAXPOS_PATTERN, MINPOS_PATTERN);
    send_op(OP_SUB, MINPOS_PATTERN, MAXPOS_PATTERN);
    send_op(OP_ADD, 8'h70, 8'h03);
    // Tie to even, saturation and underflow.
    send_op(OP_MUL, 8'h41, 8'h50);
    send_op(OP_MUL, MAXPOS_PATTERN, MAXPOS_PATTERN);
    send_op(OP_MUL, 8'h7C, 8'h7C);
    send_op(OP_MUL, MINPOS_PATTERN, MINPOS_PATTERN);
    send_op(OP_MUL, 8'h02, 8'hFD);
    // NaR on either side for every opcode.
    for (int i = 0; i < 3; i++) begin
      send_op(operation_e'(i), NAR_PATTERN, 8'h40);
      send_op(operation_e'(i), 8'h40, NAR_PATTERN);
      send_op(operation_e'(i), NAR_PATTERN, ZERO_PATTERN);
    end
    // Zero operands.
    send_op(OP_ADD, ZERO_PATTERN, 8'h5A);
    send_op(OP_SUB, ZERO_PATTERN, 8'h5A);
    send_op(OP_ADD, 8'h5A, ZERO_PATTERN);
    send_op(OP_SUB, ZERO_PATTERN, ZERO_PATTERN);
    send_op(OP_MUL, ZERO_PATTERN, 8'h5A);
    send_op(OP_MUL, 8'hA6, ZERO_PATTERN);
  endtask

  task automatic run_random(input int n);
    for (int i = 0; i < n; i++) begin
      if (($random(seed) & 3) != 0) send_op(pick_op(), pick_operand(), pick_operand());
      else idle_cycle();
    end
  endtask

  initial begin
    seed       = 32'h6939;
    edge_cnt   = 0;
    in_count   = 0;
    out_count  = 0;
    posit_errs = 0;
    flag_errs  = 0;
    count_errs = 0;
    other_errs = 0;
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    op_i       = OP_ADD;
    operand1_i = ZERO_PATTERN;
    operand2_i = ZERO_PATTERN;
    repeat (10) @(posedge clk_i);
    #2;
    compare_logic("reset out_valid", 1'b0, out_valid_o);
    compare_posit("reset result", ZERO_PATTERN, result_o);
    rst_n_i = 1'b1;
    repeat (4) idle_cycle();
    run_directed();
    repeat (4) idle_cycle();
    run_random(3000);
    idle_cycle();
    drain_cycles = 0;
    while (exp_q.size() != 0 && drain_cycles < 20) begin
      @(posedge clk_i);
      drain_cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out with %0d results still in flight", exp_q.size());
      other_errs++;
    end
    @(negedge clk_i);
    compare_count("output count", in_count, out_count);
    $display("Errors: posit %0d, flag %0d, count %0d, other %0d (%0d operations)",
             posit_errs, flag_errs, count_errs, other_errs, in_count);
    if (posit_errs + flag_errs + count_errs + other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : ppu_tb

`default_nettype wire

// ==== flist.f ====
source/ppu_pkg.sv
source/ppu_decode.sv
source/ppu_execute.sv
source/ppu_result.sv
source/ppu.sv
verif/ppu_tb.sv

// ==== Bender.yml ====
package:
  name: ppu

sources:
  - files:
      - source/ppu_pkg.sv
      - source/ppu_decode.sv
      - source/ppu_execute.sv
      - source/ppu_result.sv
      - source/ppu.sv
  - target: simulation
    files:
      - verif/ppu_tb.sv
